/* Bender.yml */
package:
  name: cache

sources:
  - target: any(rtl, test)
    include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/bus_pkg.sv
      - rtl/cache_ifs.sv
      - rtl/cache_ctrl.sv
      - rtl/cache_tags.sv
      - rtl/cache_data.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/cache_tb_mem.sv
      - verif/cache_tb.sv

/* filelist.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/bus_pkg.sv
rtl/cache_ifs.sv
rtl/cache_ctrl.sv
rtl/cache_tags.sv
rtl/cache_data.sv
rtl/cache_top.sv
verif/cache_tb_mem.sv
verif/cache_tb.sv

/* rtl/bus_pkg.sv */
`default_nettype none
`include "cache_params.svh"

package bus_pkg;

    // a whole block as stored and as moved on the bus
    typedef logic [`CACHE_BLOCK_BITS-1:0] block_t;

    // one enable per byte of a block
    typedef logic [`CACHE_BLOCK_BITS/8-1:0] block_mask_t;

endpackage

`default_nettype wire

/* rtl/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_ctrl
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        nreset_i,
    input  wire logic        cc_valid_i,
    output logic             cc_ready_o,
    input  wire logic        cc_we_i,
    input  wire logic [3:0]  cc_be_i,
    input  wire addr_u       cc_addr_i,
    input  wire logic [31:0] cc_wdata_i,
    output logic             cc_valid_o,
    output logic [31:0]      cc_rdata_o,
    output logic             cb_valid_o,
    input  wire logic        cb_yumi_i,
    output logic             cb_we_o,
    output logic [31:0]      cb_addr_o,
    output block_t           cb_wdata_o,
    input  wire logic        cb_valid_i,
    input  wire block_t      cb_data_i,
    tag_if.ctrl              tags,
    data_if.ctrl             data
);
    typedef enum logic [2:0] {
        s_idle, s_lookup, s_evict, s_fill_req, s_fill_wait
    } ctrl_state_t;

    ctrl_state_t state_q, state_d;

    addr_u       req_addr_q;
    logic        req_we_q;
    logic [3:0]  req_be_q;
    logic [31:0] req_wdata_q;

    logic  accept, in_lookup, miss, write_hit, fill_now;
    addr_u wb_addr, fill_addr;

    assign accept    = cc_valid_i & cc_ready_o;
    assign in_lookup = state_q == s_lookup;
    assign miss      = in_lookup & ~tags.hit;
    assign write_hit = in_lookup & tags.hit & req_we_q;
    assign fill_now  = (state_q == s_fill_wait) & cb_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle:      state_d = accept ? s_lookup : s_idle;
            s_lookup: begin
                if (tags.hit) begin
                    state_d = s_idle;
                end else if (tags.victim_dirty) begin
                    state_d = cb_yumi_i ? s_fill_req : s_evict;
                end else begin
                    // clean miss asks for the fill right away
                    state_d = cb_yumi_i ? s_fill_wait : s_fill_req;
                end
            end
            s_evict:     state_d = cb_yumi_i ? s_fill_req : s_evict;
            s_fill_req:  state_d = cb_yumi_i ? s_fill_wait : s_fill_req;
            s_fill_wait: state_d = cb_valid_i ? s_idle : s_fill_wait;
            default:     state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_q <= s_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q  <= cc_addr_i;
            req_we_q    <= cc_we_i;
            req_be_q    <= cc_be_i;
            req_wdata_q <= cc_wdata_i;
        end
    end

    // bus addresses are block aligned
    always_comb begin
        wb_addr           = '0;
        wb_addr.f.tag     = tags.victim_tag;
        wb_addr.f.index   = req_addr_q.f.index;
        fill_addr         = '0;
        fill_addr.f.tag   = req_addr_q.f.tag;
        fill_addr.f.index = req_addr_q.f.index;
    end

    assign cc_ready_o = (state_q == s_idle) & tags.sweep_done;
    assign cc_valid_o = (in_lookup & tags.hit) | fill_now;
    assign cc_rdata_o = req_we_q ? 32'd0 : data.rdata_word;

    assign cb_valid_o = miss | (state_q == s_evict) | (state_q == s_fill_req);
    assign cb_we_o    = (miss & tags.victim_dirty) | (state_q == s_evict);
    assign cb_addr_o  = cb_we_o ? wb_addr.raw : fill_addr.raw;
    assign cb_wdata_o = data.victim_block;

    // new index on acceptance, then hold the registered one
    assign tags.lookup     = accept ? cc_addr_i.f.index : req_addr_q.f.index;
    assign tags.req_addr   = req_addr_q;
    assign tags.fill       = fill_now;
    assign tags.mark_dirty = write_hit;
    assign tags.fill_dirty = req_we_q;

    assign data.rd        = accept;
    assign data.index     = tags.lookup;
    assign data.wr        = write_hit;
    assign data.way       = (in_lookup & tags.hit) ? tags.hit_way : tags.victim_way;
    assign data.word      = req_addr_q.f.word;
    // a read merges nothing into the fill
    assign data.be        = req_we_q ? req_be_q : 4'b0000;
    assign data.wdata     = req_wdata_q;
    assign data.fill      = fill_now;
    assign data.fill_data = cb_data_i;

endmodule

`default_nettype wire

/* rtl/cache_data.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_data
    import cache_pkg::*;
    import bus_pkg::*;
(
    input wire logic clk_i,
    data_if.array    data
);
    block_t      mem  [2][`CACHE_SETS];
    block_t      rd_q [2];

    block_mask_t mask;
    block_t      wdata_rep;
    block_t      merged;
    block_t      word_src;

    // core bytes placed at the requested word
    assign mask      = block_mask_t'(data.be) << {data.word, 2'b00};
    assign wdata_rep = {`CACHE_BLOCK_WORDS{data.wdata}};

    always_comb begin
        for (int b = 0; b < `CACHE_BLOCK_BITS / 8; b++) begin
            merged[b*8 +: 8] = mask[b] ? wdata_rep[b*8 +: 8] : data.fill_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (data.wr | data.fill) begin
            // fill writes every byte, a write hit only the masked ones
            for (int b = 0; b < `CACHE_BLOCK_BITS / 8; b++) begin
                if (data.fill | mask[b]) begin
                    mem[data.way][data.index][b*8 +: 8] <= merged[b*8 +: 8];
                end
            end
        end
        if (data.rd) begin
            rd_q[0] <= mem[0][data.index];
            rd_q[1] <= mem[1][data.index];
        end
    end

    // arriving block answers a miss directly
    assign word_src          = data.fill ? data.fill_data : rd_q[data.way];
    assign data.rdata_word   = word_src[{data.word, 5'b00000} +: 32];
    assign data.victim_block = rd_q[data.way];

endmodule

`default_nettype wire

/* rtl/cache_ifs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

interface tag_if
    import cache_pkg::*;
();
    // set to read with the result one cycle later
    logic [`CACHE_INDEX_BITS-1:0] lookup;
    addr_u                        req_addr;
    logic                         fill;
    logic                         mark_dirty;
    logic                         fill_dirty;

    logic                         hit;
    way_t                         hit_way;
    way_t                         victim_way;
    logic                         victim_dirty;
    logic [`CACHE_TAG_BITS-1:0]   victim_tag;
    logic                         sweep_done;

    modport ctrl (
        output lookup, req_addr, fill, mark_dirty, fill_dirty,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, sweep_done
    );

    modport tags (
        input  lookup, req_addr, fill, mark_dirty, fill_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag, sweep_done
    );
endinterface

interface data_if
    import cache_pkg::*;
    import bus_pkg::*;
();
    logic                         rd;
    logic [`CACHE_INDEX_BITS-1:0] index;
    logic                         wr;
    way_t                         way;
    logic [`CACHE_WORD_BITS-1:0]  word;
    logic [3:0]                   be;
    logic [31:0]                  wdata;
    logic                         fill;
    block_t                       fill_data;

    logic [31:0]                  rdata_word;
    block_t                       victim_block;

    modport ctrl (
        output rd, index, wr, way, word, be, wdata, fill, fill_data,
        input  rdata_word, victim_block
    );

    modport array (
        input  rd, index, wr, way, word, be, wdata, fill, fill_data,
        output rdata_word, victim_block
    );
endinterface

`default_nettype wire

/* rtl/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// number of sets and words per block
`define CACHE_SETS        16
`define CACHE_BLOCK_WORDS 4

// the low two address bits select the byte
`define CACHE_INDEX_BITS  $clog2(`CACHE_SETS)
`define CACHE_WORD_BITS   $clog2(`CACHE_BLOCK_WORDS)

// tag gets whatever is left of the 32-bit address
`define CACHE_TAG_BITS    (32 - `CACHE_INDEX_BITS - `CACHE_WORD_BITS - 2)

// one block is also one bus transfer
`define CACHE_BLOCK_BITS  (`CACHE_BLOCK_WORDS * 32)

`endif

/* rtl/cache_pkg.sv */
`default_nettype none
`include "cache_params.svh"

package cache_pkg;

    // field view of a core address
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [`CACHE_WORD_BITS-1:0]  word;
        logic [1:0]                   byte_sel;
    } addr_fields_t;

    // same 32 bits read raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } addr_u;

    typedef enum logic [1:0] {
        st_invalid = 2'd0,
        st_clean   = 2'd1,
        st_dirty   = 2'd2
    } block_state_t;

    // two ways only
    typedef logic way_t;

endpackage

`default_nettype wire

/* rtl/cache_tags.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_tags
    import cache_pkg::*;
(
    input wire logic clk_i,
    input wire logic nreset_i,
    tag_if.tags      tags
);
    logic [`CACHE_TAG_BITS-1:0]   tag_mem   [2][`CACHE_SETS];
    block_state_t                 state_mem [2][`CACHE_SETS];
    way_t                         lru_mem   [`CACHE_SETS];

    logic [`CACHE_TAG_BITS-1:0]   rd_tag_q   [2];
    block_state_t                 rd_state_q [2];
    way_t                         rd_lru_q;

    logic [`CACHE_INDEX_BITS:0]   sweep_q;
    logic [`CACHE_INDEX_BITS-1:0] set_idx;
    logic [1:0]                   match;

    assign set_idx         = tags.req_addr.f.index;
    // msb set once every set has been cleared
    assign tags.sweep_done = sweep_q[`CACHE_INDEX_BITS];

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            sweep_q <= '0;
        end else if (!tags.sweep_done) begin
            sweep_q <= sweep_q + 1'b1;
        end
    end

    // whole set read every cycle
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < 2; w++) begin
            rd_tag_q[w]   <= tag_mem[w][tags.lookup];
            rd_state_q[w] <= state_mem[w][tags.lookup];
        end
        rd_lru_q <= lru_mem[tags.lookup];
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = (rd_state_q[w] != st_invalid) && (rd_tag_q[w] == tags.req_addr.f.tag);
        end
    end

    assign tags.hit     = |match;
    assign tags.hit_way = match[1];

    // empty way first, lru way otherwise
    assign tags.victim_way   = (rd_state_q[0] == st_invalid) ? 1'b0 :
                               (rd_state_q[1] == st_invalid) ? 1'b1 : rd_lru_q;
    assign tags.victim_dirty = rd_state_q[tags.victim_way] == st_dirty;
    assign tags.victim_tag   = rd_tag_q[tags.victim_way];

    always_ff @(posedge clk_i) begin
        if (!tags.sweep_done) begin
            state_mem[0][sweep_q[`CACHE_INDEX_BITS-1:0]] <= st_invalid;
            state_mem[1][sweep_q[`CACHE_INDEX_BITS-1:0]] <= st_invalid;
            lru_mem[sweep_q[`CACHE_INDEX_BITS-1:0]]      <= 1'b0;
        end else if (tags.fill) begin
            tag_mem[tags.victim_way][set_idx]   <= tags.req_addr.f.tag;
            state_mem[tags.victim_way][set_idx] <= tags.fill_dirty ? st_dirty : st_clean;
            lru_mem[set_idx]                    <= ~tags.victim_way;
        end else if (tags.hit) begin
            // while idle the last hit repeats, rewriting the same lru value
            if (tags.mark_dirty) begin
                state_mem[tags.hit_way][set_idx] <= st_dirty;
            end
            lru_mem[set_idx] <= ~tags.hit_way;
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_top (
    input  wire logic                         clk_i,
    input  wire logic                         nreset_i,

    input  wire logic                         cc_valid_i,
    output logic                              cc_ready_o,
    input  wire logic                         cc_we_i,
    input  wire logic [3:0]                   cc_be_i,
    input  wire logic [31:0]                  cc_addr_i,
    input  wire logic [31:0]                  cc_wdata_i,
    output logic                              cc_valid_o,
    output logic [31:0]                       cc_rdata_o,

    output logic                              cb_valid_o,
    output logic                              cb_we_o,
    output logic [31:0]                       cb_addr_o,
    output logic [`CACHE_BLOCK_BITS-1:0]      cb_wdata_o,
    input  wire logic                         cb_yumi_i,
    input  wire logic                         cb_valid_i,
    input  wire logic [`CACHE_BLOCK_BITS-1:0] cb_data_i
);
    tag_if  tag_bus ();
    data_if data_bus ();

    cache_ctrl u_ctrl (
        .clk_i,
        .nreset_i,
        .cc_valid_i,
        .cc_ready_o,
        .cc_we_i,
        .cc_be_i,
        .cc_addr_i,
        .cc_wdata_i,
        .cc_valid_o,
        .cc_rdata_o,
        .cb_valid_o,
        .cb_yumi_i,
        .cb_we_o,
        .cb_addr_o,
        .cb_wdata_o,
        .cb_valid_i,
        .cb_data_i,
        .tags (tag_bus),
        .data (data_bus)
    );

    cache_tags u_tags (
        .clk_i,
        .nreset_i,
        .tags (tag_bus)
    );

    cache_data u_data (
        .clk_i,
        .data (data_bus)
    );

endmodule

`default_nettype wire

/* verif/cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_tb;
    localparam int num_reqs    = 400;
    // about 20 cycles per request at worst plus margin
    localparam int max_cycles  = num_reqs * 30;
    localparam int block_bytes = `CACHE_BLOCK_WORDS * 4;

    logic                         clk_i;
    logic                         nreset_i;
    logic                         cc_valid_i;
    logic                         cc_ready_o;
    logic                         cc_we_i;
    logic [3:0]                   cc_be_i;
    logic [31:0]                  cc_addr_i;
    logic [31:0]                  cc_wdata_i;
    logic                         cc_valid_o;
    logic [31:0]                  cc_rdata_o;
    logic                         cb_valid_o;
    logic                         cb_we_o;
    logic [31:0]                  cb_addr_o;
    logic [`CACHE_BLOCK_BITS-1:0] cb_wdata_o;
    logic                         cb_yumi_i;
    logic                         cb_valid_i;
    logic [`CACHE_BLOCK_BITS-1:0] cb_data_i;

    int cycle       = 0;
    int since_reset = 0;
    int err_data    = 0;
    int err_timing  = 0;
    int err_bus     = 0;
    int err_other   = 0;

    // one entry per accepted request with the oldest first
    logic        exp_we    [$];
    logic [31:0] exp_rdata [$];
    logic [31:0] exp_addr  [$];
    logic        exp_hit   [$];
    int          exp_cycle [$];

    // golden byte image where untouched bytes follow the memory pattern
    logic [7:0] gold [logic [31:0]];

    logic        bus_waiting = 1'b0;
    logic        after_wb    = 1'b0;
    logic        held_we;
    logic [31:0] held_addr;

    cache_top cache_top_i (
        .clk_i, .nreset_i,
        .cc_valid_i, .cc_ready_o, .cc_we_i, .cc_be_i, .cc_addr_i, .cc_wdata_i,
        .cc_valid_o, .cc_rdata_o,
        .cb_valid_o, .cb_we_o, .cb_addr_o, .cb_wdata_o, .cb_yumi_i,
        .cb_valid_i, .cb_data_i
    );

    cache_tb_mem bus_mem (
        .clk_i, .nreset_i,
        .cb_valid_i (cb_valid_o),
        .cb_we_i    (cb_we_o),
        .cb_addr_i  (cb_addr_o),
        .cb_wdata_i (cb_wdata_o),
        .cb_yumi_o  (cb_yumi_i),
        .cb_valid_o (cb_valid_i),
        .cb_data_o  (cb_data_i)
    );

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] init_word;
        logic [31:0] ba;
        logic [31:0] word;
        // word address is the byte address without its two low bits
        init_word = addr[31:2] ^ 32'hc0de_0000;
        for (int b = 0; b < 4; b++) begin
            ba = {addr[31:2], 2'b00} + b;
            word[b*8 +: 8] = gold.exists(ba) ? gold[ba] : init_word[b*8 +: 8];
        end
        return word;
    endfunction

    task automatic ref_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                gold[{addr[31:2], 2'b00} + b] = wdata[b*8 +: 8];
            end
        end
    endtask

    // three tags over four sets overflow both ways of some sets
    function automatic logic [31:0] make_addr();
        logic [31:0] tag;
        logic [31:0] set;
        logic [31:0] word;
        tag  = 32'h12 + $urandom_range(0, 2) * 32'h5_3c9;
        set  = ($urandom_range(0, 3) * 5 + 1) % `CACHE_SETS;
        word = $urandom_range(0, `CACHE_BLOCK_WORDS - 1);
        return (tag << (`CACHE_INDEX_BITS + `CACHE_WORD_BITS + 2))
             | (set << (`CACHE_WORD_BITS + 2))
             | (word << 2);
    endfunction

    task automatic finish_run();
        $display("errors: data %0d, timing %0d, bus %0d, other %0d",
                 err_data, err_timing, err_bus, err_other);
        if (err_data + err_timing + err_bus + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (nreset_i) begin
            since_reset <= 0;
        end else begin
            since_reset <= since_reset + 1;
            if (cc_ready_o && since_reset < `CACHE_SETS) begin
                $display("cc_ready_o rose %0d cycles after reset, before the sweep ended",
                         since_reset);
                err_other++;
            end
        end
    end

    initial begin : driver
        logic [31:0] addr;
        logic [31:0] prev_addr;
        logic        prev_valid;
        logic        we;
        logic        repeat_rd;
        logic [3:0]  be;
        int unsigned start;
        int unsigned len;

        void'($urandom(32'h3a53_8b33));
        nreset_i   = 1'b1;
        cc_valid_i = 1'b0;
        cc_we_i    = 1'b0;
        cc_be_i    = 4'h0;
        cc_addr_i  = '0;
        cc_wdata_i = '0;
        prev_addr  = '0;
        prev_valid = 1'b0;
        repeat (2) @(posedge clk_i);
        nreset_i <= 1'b0;
        for (int n = 0; n < num_reqs; n++) begin
            if (prev_valid && $urandom_range(0, 3) == 0) begin
                addr = prev_addr;
            end else begin
                addr = make_addr();
            end
            we = $urandom_range(0, 1);
            repeat_rd = !we && prev_valid && (addr == prev_addr);
            // contiguous byte run inside the word
            start = $urandom_range(0, 3);
            len   = $urandom_range(1, 4 - start);
            be    = we ? ((4'b0001 << len) - 4'b0001) << start : 4'hf;
            cc_valid_i <= 1'b1;
            cc_we_i    <= we;
            cc_be_i    <= be;
            cc_addr_i  <= addr;
            cc_wdata_i <= $urandom;
            @(posedge clk_i);
            while (!cc_ready_o) @(posedge clk_i);
            exp_we.push_back(we);
            exp_rdata.push_back(we ? 32'd0 : ref_read(addr));
            exp_addr.push_back(addr);
            exp_hit.push_back(repeat_rd);
            exp_cycle.push_back(cycle);
            if (we) begin
                ref_write(addr, be, cc_wdata_i);
            end
            prev_addr  = addr;
            prev_valid = 1'b1;
        end
        cc_valid_i <= 1'b0;
        while (exp_we.size() != 0) @(posedge clk_i);
        finish_run();
    end

    always @(posedge clk_i) begin : compare
        logic [31:0] want;
        logic [31:0] addr;
        logic        hit;
        int          acc_cycle;
        if (!nreset_i && cc_valid_o) begin
            if (exp_we.size() == 0) begin
                $display("response pulse at cycle %0d without an accepted request", cycle);
                err_other++;
            end else begin
                void'(exp_we.pop_front());
                want      = exp_rdata.pop_front();
                addr      = exp_addr.pop_front();
                hit       = exp_hit.pop_front();
                acc_cycle = exp_cycle.pop_front();
                if (cc_rdata_o !== want) begin
                    $display("Error: cc_rdata_o = %h, expected %h, addr %h",
                             cc_rdata_o, want, addr);
                    err_data++;
                end
                if (hit && cycle - acc_cycle != 1) begin
                    $display("repeated read of %h answered %0d cycles after acceptance",
                             addr, cycle - acc_cycle);
                    err_timing++;
                end
            end
        end
    end

    always @(posedge clk_i) begin : bus_check
        logic [31:0] wb_want;
        if (!nreset_i) begin
            if (cb_valid_o && (cb_addr_o % block_bytes) != 0) begin
                $display("Error: cb_addr_o = %h is not block aligned", cb_addr_o);
                err_bus++;
            end
            if (bus_waiting && !cb_valid_o) begin
                $display("bus request withdrawn before cb_yumi_i");
                err_bus++;
            end else if (bus_waiting && (cb_addr_o !== held_addr || cb_we_o !== held_we)) begin
                $display("Error: cb_addr_o = %h, cb_we_o = %h changed from %h, %h",
                         cb_addr_o, cb_we_o, held_addr, held_we);
                err_bus++;
            end
            if (cb_valid_o && cb_yumi_i) begin
                if (after_wb && cb_we_o) begin
                    $display("write-back followed by another write-back");
                    err_bus++;
                end
                // a dirty victim carries every earlier write to its block
                if (cb_we_o) begin
                    for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
                        wb_want = ref_read(cb_addr_o + 4 * w);
                        if (cb_wdata_o[w*32 +: 32] !== wb_want) begin
                            $display("Error: cb_wdata_o word %0d = %h, expected %h, addr %h",
                                     w, cb_wdata_o[w*32 +: 32], wb_want, cb_addr_o);
                            err_bus++;
                        end
                    end
                end
                after_wb = cb_we_o;
            end
            bus_waiting = cb_valid_o && !cb_yumi_i;
            held_addr   = cb_addr_o;
            held_we     = cb_we_o;
        end
    end

    initial begin : watchdog
        while (cycle < max_cycles) @(posedge clk_i);
        $display("timeout, run stopped after %0d cycles", cycle);
        err_other++;
        finish_run();
    end

endmodule

`default_nettype wire

/* verif/cache_tb_mem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_tb_mem (
    input  wire logic                         clk_i,
    input  wire logic                         nreset_i,
    input  wire logic                         cb_valid_i,
    input  wire logic                         cb_we_i,
    input  wire logic [31:0]                  cb_addr_i,
    input  wire logic [`CACHE_BLOCK_BITS-1:0] cb_wdata_i,
    output logic                              cb_yumi_o,
    output logic                              cb_valid_o,
    output logic [`CACHE_BLOCK_BITS-1:0]      cb_data_o
);
    // only written words are kept, the rest follow the fill pattern
    logic [31:0] words [logic [31:0]];
    int unsigned yumi_wait;
    int unsigned fill_wait;
    logic        fill_pending;
    logic [31:0] fill_addr;

    task automatic store_block(input logic [31:0] addr,
                               input logic [`CACHE_BLOCK_BITS-1:0] blk);
        for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
            words[addr[31:2] + w] = blk[w*32 +: 32];
        end
    endtask

    function automatic logic [`CACHE_BLOCK_BITS-1:0] load_block(input logic [31:0] addr);
        logic [`CACHE_BLOCK_BITS-1:0] blk;
        logic [31:0]                  key;
        for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
            key = addr[31:2] + w;
            blk[w*32 +: 32] = words.exists(key) ? words[key] : (key ^ 32'hc0de_0000);
        end
        return blk;
    endfunction

    initial begin
        cb_yumi_o    = 1'b0;
        cb_valid_o   = 1'b0;
        cb_data_o    = '0;
        fill_pending = 1'b0;
        fill_addr    = '0;
        yumi_wait    = 0;
        fill_wait    = 0;
    end

    always @(posedge clk_i) begin
        cb_valid_o <= 1'b0;
        if (nreset_i) begin
            cb_yumi_o    <= 1'b0;
            fill_pending <= 1'b0;
            yumi_wait    <= $urandom_range(0, 3);
        end else begin
            if (cb_valid_i && cb_yumi_o) begin
                // request taken at this edge
                cb_yumi_o <= 1'b0;
                yumi_wait <= $urandom_range(0, 3);
                if (cb_we_i) begin
                    store_block(cb_addr_i, cb_wdata_i);
                end else begin
                    fill_pending <= 1'b1;
                    fill_addr    <= cb_addr_i;
                    fill_wait    <= $urandom_range(0, 3);
                end
            end else if (cb_valid_i) begin
                if (yumi_wait == 0) begin
                    cb_yumi_o <= 1'b1;
                end else begin
                    yumi_wait <= yumi_wait - 1;
                end
            end
            if (fill_pending) begin
                if (fill_wait == 0) begin
                    cb_valid_o   <= 1'b1;
                    cb_data_o    <= load_block(fill_addr);
                    fill_pending <= 1'b0;
                end else begin
                    fill_wait <= fill_wait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire
